// ==== uart_macros.svh ====
`ifndef UART_MACROS_SVH
`define UART_MACROS_SVH

// ------------------------------------------------
// Register map, APB word addresses PADDR[11:2]
// ------------------------------------------------
`define UART_ADDR_W      10

`define UART_ADDR_DATA   10'h000 // RX byte on read, TX byte on write
`define UART_ADDR_STAT   10'h001 // Overrun W1C, buffer full RO
`define UART_ADDR_CTRL   10'h002 // Enables
`define UART_ADDR_INTR   10'h003 // Interrupt status, W1C
`define UART_ADDR_BAUD   10'h004 // Integer baud divider

// ------------------------------------------------
// Datapath sizes
// ------------------------------------------------
`define UART_DATA_W      8  // 8N1 character
`define UART_BAUD_W      16 // Divider, minimum useful value 2
`define UART_OVERSAMPLE  16 // Ticks per bit

`endif

// ==== apb_pkg.sv ====
`include "uart_macros.svh"

package apb_pkg;

  // One request from the APB master as seen by the slave
  typedef struct packed {
    logic                    psel;    // Slave select
    logic                    penable; // Access phase
    logic                    pwrite;  // 1 write, 0 read
    logic [`UART_ADDR_W-1:0] paddr;   // Word address
    logic [31:0]             pwdata;  // Write data
  } apb_req_t;

endpackage

// ==== uart_pkg.sv ====
package uart_pkg;

  // Control register, bit 5 down to bit 0
  typedef struct packed {
    logic rx_ovr_en; // RX overrun interrupt enable
    logic tx_ovr_en; // TX overrun interrupt enable
    logic rx_int_en; // RX interrupt enable
    logic tx_int_en; // TX interrupt enable
    logic rx_en;
    logic tx_en;
  } uart_ctrl_t;

  // Status register, bit 3 down to bit 0
  typedef struct packed {
    logic rx_ovr;  // Sticky, W1C
    logic tx_ovr;  // Sticky, W1C
    logic rx_full; // Read only
    logic tx_full; // Read only
  } uart_stat_t;

  // Interrupt status, also the four interrupt pins
  typedef struct packed {
    logic rx_ovr;
    logic tx_ovr;
    logic rx;
    logic tx;
  } uart_intr_t;

  // Transmitter strobes, one cycle each
  typedef struct packed {
    logic load;    // Buffer moved into shifter
    logic overrun; // Write hit a full buffer
  } tx_event_t;

  // Receiver strobes, one cycle each
  typedef struct packed {
    logic sample;  // Byte completed into buffer
    logic overrun; // Byte completed over an unread one
  } rx_event_t;

endpackage

// ==== uart_regs.sv ====
`include "uart_macros.svh"

module uart_regs (
  input  logic                    PCLK,
  input  logic                    PRESETn,
  input  apb_pkg::apb_req_t       apb_req_i,
  input  logic                    tx_full_i,
  input  uart_pkg::tx_event_t     tx_ev_i,
  input  logic                    rx_full_i,
  input  uart_pkg::rx_event_t     rx_ev_i,
  input  logic [`UART_DATA_W-1:0] rx_data_i,
  output logic [31:0]             prdata_o,
  output uart_pkg::uart_ctrl_t    ctrl_o,
  output logic                    tx_write_o,
  output logic [`UART_DATA_W-1:0] tx_data_o,
  output logic                    rx_read_o,
  output logic                    baud_load_o,
  output logic [`UART_BAUD_W-1:0] baud_div_o,
  output uart_pkg::uart_intr_t    intr_o,
  output logic                    uart_int_o
);

  logic                 wr_setup;   // First cycle of a write
  logic                 rd_setup;   // First cycle of a read
  logic                 rd_access;  // Second cycle of a read
  logic                 wr_stat;
  logic                 wr_ctrl;
  logic                 wr_intr;
  logic                 rx_ovr_q;
  logic                 tx_ovr_q;
  logic                 rx_int_q;
  logic                 tx_int_q;
  logic                 rx_ovr_clr;
  logic                 tx_ovr_clr;
  logic                 rx_int_set;
  logic                 tx_int_set;
  uart_pkg::uart_stat_t stat;
  logic [31:0]          rd_mux;
  logic [31:0]          rd_q;       // Read value held for the access cycle

  // ------------------------------------------------
  // APB decode
  // ------------------------------------------------
  assign wr_setup  = apb_req_i.psel & ~apb_req_i.penable & apb_req_i.pwrite;
  assign rd_setup  = apb_req_i.psel & ~apb_req_i.penable & ~apb_req_i.pwrite;
  assign rd_access = apb_req_i.psel & apb_req_i.penable & ~apb_req_i.pwrite;

  assign tx_write_o  = wr_setup & (apb_req_i.paddr == `UART_ADDR_DATA);
  assign wr_stat     = wr_setup & (apb_req_i.paddr == `UART_ADDR_STAT);
  assign wr_ctrl     = wr_setup & (apb_req_i.paddr == `UART_ADDR_CTRL);
  assign wr_intr     = wr_setup & (apb_req_i.paddr == `UART_ADDR_INTR);
  assign baud_load_o = wr_setup & (apb_req_i.paddr == `UART_ADDR_BAUD);
  assign rx_read_o   = rd_setup & (apb_req_i.paddr == `UART_ADDR_DATA); // Pops RX buffer

  assign tx_data_o = apb_req_i.pwdata[`UART_DATA_W-1:0]; // Valid with tx_write_o

  // Control and divider
  always_ff @(posedge PCLK or negedge PRESETn)
  begin
    if (!PRESETn)
    begin
      ctrl_o     <= '0;
      baud_div_o <= '0;
    end
    else
    begin
      if (wr_ctrl)
        ctrl_o <= apb_req_i.pwdata[$bits(uart_pkg::uart_ctrl_t)-1:0];
      if (baud_load_o)
        baud_div_o <= apb_req_i.pwdata[`UART_BAUD_W-1:0];
    end
  end

  // ------------------------------------------------
  // Overrun and interrupt flags
  // ------------------------------------------------
  // Overruns clear from either STAT or INTR
  assign rx_ovr_clr = (wr_stat | wr_intr) & apb_req_i.pwdata[3];
  assign tx_ovr_clr = (wr_stat | wr_intr) & apb_req_i.pwdata[2];

  assign rx_int_set = ctrl_o.rx_int_en & rx_ev_i.sample;
  assign tx_int_set = ctrl_o.tx_int_en & ctrl_o.tx_en & tx_ev_i.load; // Buffer freed

  always_ff @(posedge PCLK or negedge PRESETn)
  begin
    if (!PRESETn)
    begin
      rx_ovr_q <= 1'b0;
      tx_ovr_q <= 1'b0;
      rx_int_q <= 1'b0;
      tx_int_q <= 1'b0;
    end
    else
    begin
      // Set beats clear in the same cycle
      if (rx_ev_i.overrun)
        rx_ovr_q <= 1'b1;
      else if (rx_ovr_clr)
        rx_ovr_q <= 1'b0;
      if (tx_ev_i.overrun)
        tx_ovr_q <= 1'b1;
      else if (tx_ovr_clr)
        tx_ovr_q <= 1'b0;
      if (rx_int_set)
        rx_int_q <= 1'b1;
      else if (wr_intr && apb_req_i.pwdata[1])
        rx_int_q <= 1'b0;
      if (tx_int_set)
        tx_int_q <= 1'b1;
      else if (wr_intr && apb_req_i.pwdata[0])
        tx_int_q <= 1'b0;
    end
  end

  // Overrun interrupts are the sticky flags masked by their enables
  assign intr_o = '{rx_ovr: rx_ovr_q & ctrl_o.rx_ovr_en,
                    tx_ovr: tx_ovr_q & ctrl_o.tx_ovr_en,
                    rx:     rx_int_q,
                    tx:     tx_int_q};
  assign uart_int_o = |intr_o;

  assign stat = '{rx_ovr: rx_ovr_q, tx_ovr: tx_ovr_q, rx_full: rx_full_i, tx_full: tx_full_i};

  // ------------------------------------------------
  // Read path
  // ------------------------------------------------
  always_comb
  begin
    rd_mux = '0; // Zero extend, unused addresses read zero
    case (apb_req_i.paddr)
      `UART_ADDR_DATA: rd_mux[`UART_DATA_W-1:0] = rx_data_i;
      `UART_ADDR_STAT: rd_mux[$bits(uart_pkg::uart_stat_t)-1:0] = stat;
      `UART_ADDR_CTRL: rd_mux[$bits(uart_pkg::uart_ctrl_t)-1:0] = ctrl_o;
      `UART_ADDR_INTR: rd_mux[$bits(uart_pkg::uart_intr_t)-1:0] = intr_o;
      `UART_ADDR_BAUD: rd_mux[`UART_BAUD_W-1:0] = baud_div_o;
      default:         rd_mux = '0;
    endcase
  end

  // Latched at the end of the setup cycle
  always_ff @(posedge PCLK)
  begin
    if (rd_setup)
      rd_q <= rd_mux;
  end

  assign prdata_o = rd_access ? rd_q : '0;

  // Data writes and divider loads reach different blocks, never in one cycle
  a_no_write_load_overlap: assert property (@(posedge PCLK) disable iff (!PRESETn)
    !(tx_write_o && baud_load_o));

endmodule

// ==== baud_gen.sv ====
`include "uart_macros.svh"

module baud_gen (
  input  logic                    PCLK,
  input  logic                    PRESETn,
  input  uart_pkg::uart_ctrl_t    ctrl_i,
  input  logic                    baud_load_i,
  input  logic [`UART_BAUD_W-1:0] baud_div_i,
  output logic                    tick_o
);

  logic                    cnt_en;  // Any direction enabled
  logic                    load_q;  // Divider register updated last cycle
  logic                    reload;
  logic [`UART_BAUD_W-1:0] cnt_q;

  assign cnt_en = ctrl_i.tx_en | ctrl_i.rx_en;
  assign reload = cnt_en & (cnt_q[`UART_BAUD_W-1:1] == '0); // At one, or zero after reset

  always_ff @(posedge PCLK or negedge PRESETn)
  begin
    if (!PRESETn)
    begin
      load_q <= 1'b0;
      cnt_q  <= '0;
      tick_o <= 1'b0;
    end
    else
    begin
      load_q <= baud_load_i;
      if (load_q || reload)
        cnt_q <= baud_div_i;     // New value is in the register by now
      else if (cnt_en)
        cnt_q <= cnt_q - 1'b1;
      tick_o <= reload;          // One PCLK wide
    end
  end

  // Also catches a divider programmed below two
  a_tick_single: assert property (@(posedge PCLK) disable iff (!PRESETn)
    tick_o |=> !tick_o);

endmodule

// ==== uart_tx.sv ====
`include "uart_macros.svh"

module uart_tx (
  input  logic                    PCLK,
  input  logic                    PRESETn,
  input  uart_pkg::uart_ctrl_t    ctrl_i,
  input  logic                    tick_i,
  input  logic                    tx_write_i,
  input  logic [`UART_DATA_W-1:0] tx_data_i,
  output logic                    txd_o,
  output logic                    tx_full_o,
  output uart_pkg::tx_event_t     tx_ev_o
);

  localparam int CNT_W = $clog2(`UART_OVERSAMPLE);

  localparam logic [3:0] ST_IDLE  = 4'd0;
  localparam logic [3:0] ST_WAIT  = 4'd1;  // Align to next tick
  localparam logic [3:0] ST_START = 4'd2;
  localparam logic [3:0] ST_D0    = 4'd3;  // D0 to D7 are 3 to 10
  localparam logic [3:0] ST_D7    = 4'd10;
  localparam logic [3:0] ST_STOP  = 4'd11;

  logic [`UART_DATA_W-1:0] buf_q;      // Holding buffer
  logic [`UART_DATA_W-1:0] shift_q;
  logic [3:0]              state_q;
  logic [3:0]              state_d;
  logic [CNT_W-1:0]        tick_cnt_q;
  logic                    bit_done;   // Last tick of a bit
  logic                    take;       // Buffer into shifter
  logic                    txd_d;

  assign bit_done = tick_i & (tick_cnt_q == CNT_W'(`UART_OVERSAMPLE - 1));
  assign take = tx_full_o & ctrl_i.tx_en &
                ((state_q == ST_IDLE) | ((state_q == ST_STOP) & bit_done));

  // ------------------------------------------------
  // Holding buffer
  // ------------------------------------------------
  always_ff @(posedge PCLK)
  begin
    if (tx_write_i)
      buf_q <= tx_data_i;
  end

  always_ff @(posedge PCLK or negedge PRESETn)
  begin
    if (!PRESETn)
      tx_full_o <= 1'b0;
    else if (tx_write_i)
      tx_full_o <= 1'b1;
    else if (take)
      tx_full_o <= 1'b0;
  end

  assign tx_ev_o = '{load: take, overrun: tx_write_i & tx_full_o & ~take};

  // ------------------------------------------------
  // Frame FSM
  // ------------------------------------------------
  always_comb
  begin
    state_d = state_q;
    case (state_q)
      ST_IDLE:
        if (take)
          state_d = ST_WAIT;
      ST_WAIT:
        if (tick_i)
          state_d = ST_START;
      ST_STOP:
        if (bit_done)
          state_d = take ? ST_START : ST_IDLE; // Back to back frames
      default:
        if (state_q > ST_STOP)
          state_d = ST_IDLE;
        else if (bit_done)
          state_d = state_q + 4'd1;
    endcase
  end

  always_ff @(posedge PCLK or negedge PRESETn)
  begin
    if (!PRESETn)
    begin
      state_q    <= ST_IDLE;
      tick_cnt_q <= '0;
      txd_o      <= 1'b1;
    end
    else
    begin
      state_q <= state_d;
      if (tick_i)
        tick_cnt_q <= (state_q == ST_WAIT) ? '0 : tick_cnt_q + 1'b1;
      txd_o <= txd_d;
    end
  end

  // Shifter, LSB first, ones behind the data give the stop bit
  always_ff @(posedge PCLK)
  begin
    if (take)
      shift_q <= buf_q;
    else if (bit_done && state_q >= ST_D0 && state_q <= ST_D7)
      shift_q <= {1'b1, shift_q[`UART_DATA_W-1:1]};
  end

  assign txd_d = (state_q == ST_START) ? 1'b0 :
                 (state_q > ST_START)  ? shift_q[0] : 1'b1; // Idle high

  a_tx_state_legal: assert property (@(posedge PCLK) disable iff (!PRESETn)
    state_q <= ST_STOP);

endmodule

// ==== uart_rx.sv ====
`include "uart_macros.svh"

module uart_rx (
  input  logic                    PCLK,
  input  logic                    PRESETn,
  input  uart_pkg::uart_ctrl_t    ctrl_i,
  input  logic                    tick_i,
  input  logic                    rx_read_i,
  input  logic                    rxd_i,
  output logic [`UART_DATA_W-1:0] rx_data_o,
  output logic                    rx_full_o,
  output uart_pkg::rx_event_t     rx_ev_o
);

  localparam int CNT_W = $clog2(`UART_OVERSAMPLE);

  localparam logic [3:0] ST_IDLE  = 4'd0;
  localparam logic [3:0] ST_START = 4'd1;  // Up to middle of start bit
  localparam logic [3:0] ST_D7    = 4'd9;  // D0 to D7 are 2 to 9
  localparam logic [3:0] ST_STOP  = 4'd10;

  logic                    rxd_sync1;
  logic                    rxd_sync2;
  logic [2:0]              filt_q;     // Last three tick samples
  logic                    rx_bit;     // Majority vote
  logic [3:0]              state_q;
  logic [3:0]              state_d;
  logic [CNT_W-1:0]        tick_cnt_q;
  logic                    start_det;
  logic                    bit_done;   // Middle of a bit
  logic                    sample;     // Byte complete
  logic [`UART_DATA_W-2:0] shift_q;    // D0 to D6, last bit joins on sample

  // ------------------------------------------------
  // Synchronizer and filter
  // ------------------------------------------------
  always_ff @(posedge PCLK or negedge PRESETn)
  begin
    if (!PRESETn)
    begin
      rxd_sync1 <= 1'b1;
      rxd_sync2 <= 1'b1;
      filt_q    <= 3'b111;
    end
    else
    begin
      if (ctrl_i.rx_en) // Frozen while RX is off
      begin
        rxd_sync1 <= rxd_i;
        rxd_sync2 <= rxd_sync1;
      end
      if (tick_i)
        filt_q <= {filt_q[1:0], rxd_sync2};
    end
  end

  assign rx_bit = (filt_q[0] & filt_q[1]) | (filt_q[1] & filt_q[2]) | (filt_q[0] & filt_q[2]);

  // ------------------------------------------------
  // Frame FSM
  // ------------------------------------------------
  assign start_det = (state_q == ST_IDLE) & ~rx_bit & ctrl_i.rx_en;
  assign bit_done  = tick_i & (tick_cnt_q == CNT_W'(`UART_OVERSAMPLE - 1));
  assign sample    = (state_q == ST_D7) & bit_done;

  always_comb
  begin
    state_d = state_q;
    case (state_q)
      ST_IDLE:
        if (start_det)
          state_d = ST_START;
      ST_STOP:
        if (bit_done)
          state_d = ST_IDLE;
      default:
        if (state_q > ST_STOP)
          state_d = ST_IDLE;
        else if (bit_done)
          state_d = state_q + 4'd1;
    endcase
  end

  always_ff @(posedge PCLK or negedge PRESETn)
  begin
    if (!PRESETn)
    begin
      state_q    <= ST_IDLE;
      tick_cnt_q <= '0;
      rx_data_o  <= '0;
      rx_full_o  <= 1'b0;
    end
    else
    begin
      state_q <= state_d;
      if (start_det)
        tick_cnt_q <= CNT_W'(`UART_OVERSAMPLE / 2); // Half a bit to the middle
      else if (tick_i)
        tick_cnt_q <= tick_cnt_q + 1'b1;
      if (sample)
        rx_data_o <= {rx_bit, shift_q};
      if (sample)
        rx_full_o <= 1'b1;
      else if (rx_read_i)
        rx_full_o <= 1'b0;
    end
  end

  // Start bit shifts in first and drops out the bottom
  always_ff @(posedge PCLK)
  begin
    if (bit_done && state_q != ST_IDLE)
      shift_q <= {rx_bit, shift_q[`UART_DATA_W-2:1]};
  end

  assign rx_ev_o = '{sample: sample, overrun: sample & rx_full_o & ~rx_read_i};

endmodule

// ==== apb_uart.sv ====
`include "uart_macros.svh"

module apb_uart (
  input  logic        PCLK,
  input  logic        PRESETn,
  input  logic        PSEL,
  input  logic        PENABLE,
  input  logic        PWRITE,
  input  logic [11:2] PADDR,    // Word address
  input  logic [31:0] PWDATA,
  output logic [31:0] PRDATA,
  input  logic        RXD,
  output logic        TXD,
  output logic        TXEN,
  output logic        BAUDTICK, // x16 tick
  output logic        TXINT,
  output logic        RXINT,
  output logic        TXOVRINT,
  output logic        RXOVRINT,
  output logic        UARTINT
);

  apb_pkg::apb_req_t       apb_req;
  uart_pkg::uart_ctrl_t    ctrl;
  uart_pkg::uart_intr_t    intr;
  uart_pkg::tx_event_t     tx_ev;
  uart_pkg::rx_event_t     rx_ev;
  logic                    tx_write;
  logic                    rx_read;
  logic                    baud_load;
  logic                    tick;
  logic                    tx_full;
  logic                    rx_full;
  logic [`UART_DATA_W-1:0] tx_data;
  logic [`UART_DATA_W-1:0] rx_data;
  logic [`UART_BAUD_W-1:0] baud_div;

  assign apb_req = '{psel: PSEL, penable: PENABLE, pwrite: PWRITE, paddr: PADDR, pwdata: PWDATA};

  uart_regs u_regs (
    .PCLK        (PCLK),
    .PRESETn     (PRESETn),
    .apb_req_i   (apb_req),
    .tx_full_i   (tx_full),
    .tx_ev_i     (tx_ev),
    .rx_full_i   (rx_full),
    .rx_ev_i     (rx_ev),
    .rx_data_i   (rx_data),
    .prdata_o    (PRDATA),
    .ctrl_o      (ctrl),
    .tx_write_o  (tx_write),
    .tx_data_o   (tx_data),
    .rx_read_o   (rx_read),
    .baud_load_o (baud_load),
    .baud_div_o  (baud_div),
    .intr_o      (intr),
    .uart_int_o  (UARTINT)
  );

  baud_gen u_baud (
    .PCLK        (PCLK),
    .PRESETn     (PRESETn),
    .ctrl_i      (ctrl),
    .baud_load_i (baud_load),
    .baud_div_i  (baud_div),
    .tick_o      (tick)
  );

  uart_tx u_tx (
    .PCLK       (PCLK),
    .PRESETn    (PRESETn),
    .ctrl_i     (ctrl),
    .tick_i     (tick),
    .tx_write_i (tx_write),
    .tx_data_i  (tx_data),
    .txd_o      (TXD),
    .tx_full_o  (tx_full),
    .tx_ev_o    (tx_ev)
  );

  uart_rx u_rx (
    .PCLK      (PCLK),
    .PRESETn   (PRESETn),
    .ctrl_i    (ctrl),
    .tick_i    (tick),
    .rx_read_i (rx_read),
    .rxd_i     (RXD),
    .rx_data_o (rx_data),
    .rx_full_o (rx_full),
    .rx_ev_o   (rx_ev)
  );

  // Pins
  assign TXEN     = ctrl.tx_en;
  assign BAUDTICK = tick;
  assign TXINT    = intr.tx;
  assign RXINT    = intr.rx;
  assign TXOVRINT = intr.tx_ovr;
  assign RXOVRINT = intr.rx_ovr;

endmodule

// ==== tb_apb_uart.sv ====
`include "uart_macros.svh"

module tb_apb_uart;

  timeunit 1ns;
  timeprecision 100ps;

  localparam int CLK_PERIOD  = 10;
  localparam int BAUD_DIV    = 16;                         // Programmed divider
  localparam int BIT_CYC     = `UART_OVERSAMPLE * BAUD_DIV; // PCLK cycles per bit
  localparam int BIT_NS      = BIT_CYC * CLK_PERIOD;
  localparam int FRAME_CYC   = 10 * BIT_CYC;               // Start, 8 data, stop
  localparam int NUM_FRAMES  = 10;                         // Frames over all tests
  localparam int TIMEOUT_CYC = NUM_FRAMES * FRAME_CYC + 2 * FRAME_CYC;

  // Control bits
  localparam logic [31:0] TX_EN   = 32'h01;
  localparam logic [31:0] RX_EN   = 32'h02;
  localparam logic [31:0] TX_IE   = 32'h04;
  localparam logic [31:0] RX_IE   = 32'h08;
  localparam logic [31:0] TXOV_IE = 32'h10;
  localparam logic [31:0] RXOV_IE = 32'h20;

  logic                    PCLK;
  logic                    PRESETn;
  logic                    psel;
  logic                    penable;
  logic                    pwrite;
  logic [`UART_ADDR_W-1:0] paddr;
  logic [31:0]             pwdata;
  logic [31:0]             prdata;
  logic                    rxd;
  logic                    txd;
  logic                    txen;
  logic                    baudtick;
  logic                    txint;
  logic                    rxint;
  logic                    txovrint;
  logic                    rxovrint;
  logic                    uartint;

  int errors    = 0;
  int checks    = 0;
  int cycle_cnt = 0;
  bit quiet     = 1'b0; // No interrupt pin may rise
  bit or_err    = 1'b0;
  bit quiet_err = 1'b0;

  apb_uart UUT (
    .PCLK     (PCLK),
    .PRESETn  (PRESETn),
    .PSEL     (psel),
    .PENABLE  (penable),
    .PWRITE   (pwrite),
    .PADDR    (paddr),
    .PWDATA   (pwdata),
    .PRDATA   (prdata),
    .RXD      (rxd),
    .TXD      (txd),
    .TXEN     (txen),
    .BAUDTICK (baudtick),
    .TXINT    (txint),
    .RXINT    (rxint),
    .TXOVRINT (txovrint),
    .RXOVRINT (rxovrint),
    .UARTINT  (uartint)
  );

  initial
  begin
    PCLK = 1'b0;
    forever #(CLK_PERIOD / 2) PCLK = ~PCLK;
  end

  // --------------------------------------------------
  // Timeout and interrupt monitors
  // --------------------------------------------------
  always @(posedge PCLK)
  begin
    cycle_cnt++;
    if (cycle_cnt >= TIMEOUT_CYC)
    begin
      $display("Run stopped by timeout after %0d cycles", cycle_cnt);
      $display("Some tests failed");
      $finish;
    end
  end

  always @(negedge PCLK)
  begin
    if (PRESETn === 1'b1)
    begin
      if (uartint !== (txint | rxint | txovrint | rxovrint) && !or_err)
      begin
        errors++; // First mismatch only
        or_err = 1'b1;
        $display("[ERROR] uartint: got 0x%h, expected 0x%h", uartint,
                 txint | rxint | txovrint | rxovrint);
      end
      if (quiet && uartint && !quiet_err)
      begin
        errors++;
        quiet_err = 1'b1;
        $display("An interrupt pin rose while all interrupt enables were clear");
      end
    end
  end

  // --------------------------------------------------
  // Expected values and compare tasks
  // --------------------------------------------------
  function automatic logic [31:0] stat_word(input logic rx_ovr, input logic tx_ovr,
                                            input logic rx_full, input logic tx_full);
    return {28'h0, rx_ovr, tx_ovr, rx_full, tx_full};
  endfunction

  function automatic uart_pkg::uart_intr_t intr_bits(input logic rx_ovr, input logic tx_ovr,
                                                     input logic rx, input logic tx);
    uart_pkg::uart_intr_t v;
    v.rx_ovr = rx_ovr;
    v.tx_ovr = tx_ovr;
    v.rx     = rx;
    v.tx     = tx;
    return v;
  endfunction

  function automatic uart_pkg::uart_intr_t intr_pins();
    return intr_bits(rxovrint, txovrint, rxint, txint);
  endfunction

  task automatic check_reg(input string name, input logic [31:0] got, input logic [31:0] exp);
    checks++;
    if (got !== exp)
    begin
      errors++;
      $display("[ERROR] %s: got 0x%08h, expected 0x%08h", name, got, exp);
    end
  endtask

  task automatic check_intr(input string name, input uart_pkg::uart_intr_t got,
                            input uart_pkg::uart_intr_t exp);
    checks++;
    if (got !== exp)
    begin
      errors++;
      $display("[ERROR] %s: got 0x%h, expected 0x%h", name, got, exp);
    end
  endtask

  task automatic check_char(input string name, input logic [`UART_DATA_W-1:0] got,
                            input logic [`UART_DATA_W-1:0] exp);
    checks++;
    if (got !== exp)
    begin
      errors++;
      $display("[ERROR] %s: got 0x%02h, expected 0x%02h", name, got, exp);
    end
  endtask

  // --------------------------------------------------
  // Bus and serial tasks, all entered at posedge + 1
  // --------------------------------------------------
  task automatic next_cycle();
    @(posedge PCLK);
    #1; // Drive point
  endtask

  task automatic hold_cycles(input int n);
    repeat (n) next_cycle();
  endtask

  task automatic apb_write(input logic [`UART_ADDR_W-1:0] addr, input logic [31:0] data);
    psel    = 1'b1; // Setup
    penable = 1'b0;
    pwrite  = 1'b1;
    paddr   = addr;
    pwdata  = data;
    next_cycle();
    penable = 1'b1; // Access
    next_cycle();
    psel    = 1'b0;
    penable = 1'b0;
  endtask

  task automatic apb_read(input logic [`UART_ADDR_W-1:0] addr, output logic [31:0] data);
    psel    = 1'b1;
    penable = 1'b0;
    pwrite  = 1'b0;
    paddr   = addr;
    next_cycle();
    penable = 1'b1;
    #(CLK_PERIOD / 2); // Mid access cycle
    data = prdata;
    next_cycle();
    psel    = 1'b0;
    penable = 1'b0;
  endtask

  task automatic read_check(input logic [`UART_ADDR_W-1:0] addr, input logic [31:0] exp,
                            input string name);
    logic [31:0] val;
    apb_read(addr, val);
    check_reg(name, val, exp);
  endtask

  task automatic send_frame(input logic [`UART_DATA_W-1:0] data);
    rxd = 1'b0; // Start bit
    hold_cycles(BIT_CYC);
    for (int i = 0; i < `UART_DATA_W; i++)
    begin
      rxd = data[i]; // LSB first
      hold_cycles(BIT_CYC);
    end
    rxd = 1'b1; // Stop bit
    hold_cycles(BIT_CYC);
  endtask

  // Falling TXD marks the frame, then sample mid bit
  task automatic capture_frame(input logic [`UART_DATA_W-1:0] exp);
    logic [`UART_DATA_W-1:0] data;
    int                      wait_cnt;
    wait_cnt = 0;
    data     = '0;
    while (txd === 1'b1 && wait_cnt < FRAME_CYC)
    begin
      next_cycle();
      wait_cnt++;
    end
    if (txd === 1'b1)
    begin
      errors++;
      $display("No start bit on TXD within %0d cycles", FRAME_CYC);
    end
    else
    begin
      #(BIT_NS / 2);
      check_reg("txd start bit", {31'b0, txd}, 32'h0);
      for (int i = 0; i < `UART_DATA_W; i++)
      begin
        #(BIT_NS);
        data[i] = txd;
      end
      #(BIT_NS);
      check_reg("txd stop bit", {31'b0, txd}, 32'h1);
      check_char("txd data", data, exp);
    end
  endtask

  task automatic wait_intr(input int idx, input string name);
    logic [3:0] pins;
    int         wait_cnt;
    wait_cnt = 0;
    pins     = intr_pins();
    while (!pins[idx] && wait_cnt < FRAME_CYC)
    begin
      next_cycle();
      wait_cnt++;
      pins = intr_pins();
    end
    if (!pins[idx])
    begin
      errors++;
      $display("%s did not rise within %0d cycles", name, FRAME_CYC);
    end
  endtask

  // Cycles from one BAUDTICK pulse to the next
  task automatic check_tick_period();
    int wait_cnt;
    int gap;
    wait_cnt = 0;
    gap      = 0;
    while (baudtick !== 1'b1 && wait_cnt < 2 * BAUD_DIV)
    begin
      next_cycle();
      wait_cnt++;
    end
    if (baudtick !== 1'b1)
    begin
      errors++;
      $display("No BAUDTICK pulse within %0d cycles", 2 * BAUD_DIV);
    end
    else
    begin
      next_cycle();
      gap = 1;
      while (baudtick !== 1'b1 && gap < 2 * BAUD_DIV)
      begin
        next_cycle();
        gap++;
      end
      check_reg("baudtick period", gap, BAUD_DIV);
    end
  endtask

  task automatic report_test(input string name, input int err_start);
    $display("Test %-18s %0d errors", name, errors - err_start);
  endtask

  // --------------------------------------------------
  // Directed tests
  // --------------------------------------------------
  task automatic reset_defaults();
    int err_start;
    err_start = errors;
    read_check(`UART_ADDR_DATA, 32'h0, "data after reset");
    read_check(`UART_ADDR_STAT, 32'h0, "stat after reset");
    read_check(`UART_ADDR_CTRL, 32'h0, "ctrl after reset");
    read_check(`UART_ADDR_INTR, 32'h0, "intr after reset");
    read_check(`UART_ADDR_BAUD, 32'h0, "baud after reset");
    check_reg("txd idle", {31'b0, txd}, 32'h1);
    check_reg("txen", {31'b0, txen}, 32'h0);
    check_reg("baudtick", {31'b0, baudtick}, 32'h0);
    check_intr("intr pins", intr_pins(), intr_bits(1'b0, 1'b0, 1'b0, 1'b0));
    apb_write(`UART_ADDR_BAUD, BAUD_DIV); // Divider before any enable
    read_check(`UART_ADDR_BAUD, BAUD_DIV, "baud readback");
    apb_write(`UART_ADDR_CTRL, RXOV_IE | TXOV_IE | RX_IE | TX_IE);
    read_check(`UART_ADDR_CTRL, 32'h3C, "ctrl readback");
    next_cycle(); // Bus idle for a cycle
    check_reg("prdata idle", prdata, 32'h0);
    read_check(10'h005, 32'h0, "unused addr 0x005");
    read_check(10'h3FF, 32'h0, "unused addr 0x3ff");
    report_test("reset_defaults", err_start);
  endtask

  task automatic tx_frame();
    int err_start;
    err_start = errors;
    apb_write(`UART_ADDR_CTRL, TX_IE | TX_EN);
    check_reg("txen", {31'b0, txen}, 32'h1);
    check_tick_period();
    apb_write(`UART_ADDR_DATA, 32'hA5);
    check_intr("txint on load", intr_pins(), intr_bits(1'b0, 1'b0, 1'b0, 1'b1));
    capture_frame(8'hA5);
    apb_write(`UART_ADDR_INTR, 32'h1); // W1C TX
    check_intr("txint cleared", intr_pins(), intr_bits(1'b0, 1'b0, 1'b0, 1'b0));
    report_test("tx_frame", err_start);
  endtask

  task automatic rx_frame();
    logic [31:0] val;
    int          err_start;
    err_start = errors;
    apb_write(`UART_ADDR_CTRL, RX_IE | RX_EN);
    send_frame(8'h3C);
    wait_intr(1, "rxint");
    read_check(`UART_ADDR_STAT, stat_word(1'b0, 1'b0, 1'b1, 1'b0), "stat rx full");
    apb_read(`UART_ADDR_DATA, val);
    check_char("rx data", val[`UART_DATA_W-1:0], 8'h3C);
    read_check(`UART_ADDR_STAT, 32'h0, "stat after read");
    apb_write(`UART_ADDR_INTR, 32'h2); // W1C RX
    check_intr("rxint cleared", intr_pins(), intr_bits(1'b0, 1'b0, 1'b0, 1'b0));
    report_test("rx_frame", err_start);
  endtask

  task automatic overrun_flags();
    logic [31:0] val;
    int          err_start;
    err_start = errors;
    apb_write(`UART_ADDR_CTRL, RXOV_IE | TXOV_IE | RX_EN | TX_EN);
    apb_write(`UART_ADDR_DATA, 32'h5A); // Straight into shifter
    apb_write(`UART_ADDR_DATA, 32'hC3); // Held in buffer
    apb_write(`UART_ADDR_DATA, 32'hC3); // Hits full buffer
    read_check(`UART_ADDR_STAT, stat_word(1'b0, 1'b1, 1'b0, 1'b1), "stat tx overrun");
    check_intr("txovrint", intr_pins(), intr_bits(1'b0, 1'b1, 1'b0, 1'b0));
    apb_write(`UART_ADDR_STAT, 32'h4);
    read_check(`UART_ADDR_STAT, stat_word(1'b0, 1'b0, 1'b0, 1'b1), "stat tx ovr cleared");
    capture_frame(8'h5A);
    capture_frame(8'hC3); // No gap after first stop bit
    send_frame(8'h11);
    send_frame(8'h22);    // Lands on unread byte
    wait_intr(3, "rxovrint");
    read_check(`UART_ADDR_STAT, stat_word(1'b1, 1'b0, 1'b1, 1'b0), "stat rx overrun");
    check_intr("rxovrint", intr_pins(), intr_bits(1'b1, 1'b0, 1'b0, 1'b0));
    apb_write(`UART_ADDR_STAT, 32'h8);
    read_check(`UART_ADDR_STAT, stat_word(1'b0, 1'b0, 1'b1, 1'b0), "stat rx ovr cleared");
    apb_read(`UART_ADDR_DATA, val);
    check_char("rx data newest", val[`UART_DATA_W-1:0], 8'h22);
    read_check(`UART_ADDR_STAT, 32'h0, "stat idle");
    report_test("overrun_flags", err_start);
  endtask

  task automatic masked_interrupts();
    int err_start;
    err_start = errors;
    apb_write(`UART_ADDR_CTRL, RX_EN | TX_EN); // All interrupt enables clear
    apb_write(`UART_ADDR_INTR, 32'hF);
    quiet = 1'b1;
    apb_write(`UART_ADDR_DATA, 32'h77);
    apb_write(`UART_ADDR_DATA, 32'h77);
    apb_write(`UART_ADDR_DATA, 32'h77);
    capture_frame(8'h77);
    capture_frame(8'h77);
    send_frame(8'h12);
    send_frame(8'h34);
    check_intr("intr pins masked", intr_pins(), intr_bits(1'b0, 1'b0, 1'b0, 1'b0));
    read_check(`UART_ADDR_INTR, 32'h0, "intr masked");
    read_check(`UART_ADDR_STAT, stat_word(1'b1, 1'b1, 1'b1, 1'b0), "stat flags unmasked");
    quiet = 1'b0;
    report_test("masked_interrupts", err_start);
  endtask

  // --------------------------------------------------
  // Main sequence
  // --------------------------------------------------
  initial
  begin
    PRESETn = 1'b0;
    psel    = 1'b0;
    penable = 1'b0;
    pwrite  = 1'b0;
    paddr   = '0;
    pwdata  = '0;
    rxd     = 1'b1; // Line idle
    hold_cycles(5);
    PRESETn = 1'b1;
    next_cycle();
    reset_defaults();
    tx_frame();
    rx_frame();
    overrun_flags();
    masked_interrupts();
    $display("Checks: %0d, errors: %0d", checks, errors);
    if (errors == 0)
      $display("All tests passed");
    else
      $display("Some tests failed");
    $finish;
  end

endmodule

// ==== apb_uart.f ====
+incdir+.
apb_pkg.sv
uart_pkg.sv
uart_regs.sv
baud_gen.sv
uart_tx.sv
uart_rx.sv
apb_uart.sv
tb_apb_uart.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_apb_uart
FILELIST  ?= apb_uart.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= All tests passed
VFLAGS    ?= --binary --timing --assert

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: build
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "^$(PASS_MSG)$$" $(LOG)

lint:
	$(VERILATOR) --lint-only --timing --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
